// ==== common/cd_pkg.sv ====
package cd_pkg;

    // ########################################################################
    // frame layout
    // ########################################################################

    localparam int frame_max = 256;        // frame buffer depth in bytes
    localparam int addr_w    = 8;          // buffer address width
    localparam int hdr_len   = 3;          // src, dst and length ahead of the payload

    // ########################################################################
    // crc-16, modbus flavour
    // ########################################################################

    localparam logic [15:0] crc_init = 16'hffff;
    localparam logic [15:0] crc_poly = 16'ha001;   // reflected form of 0x8005

    // ########################################################################
    // line timing
    // ########################################################################

    // clock cycles spent on each bit of the uart-style character
    localparam logic [15:0] bit_div = 16'd8;

endpackage

// ==== source/cd_tx_ram.sv ====
module cd_tx_ram
    import cd_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    // host side
    input  logic              wr_en,
    input  logic [addr_w-1:0] wr_addr,
    input  logic [7:0]        wr_byte,
    input  logic              tx_start,

    // fetcher side
    input  logic              ram_rd_en,
    input  logic [addr_w-1:0] ram_rd_addr,
    input  logic              ram_rd_done,
    output logic [7:0]        ram_rd_byte,
    output logic              ram_unread
);

    logic [7:0] mem [0:frame_max-1];

    // host writes only land while the buffer is not being sent
    always_ff @(posedge clk) begin
        if (wr_en && !ram_unread) begin
            mem[wr_addr] <= wr_byte;
        end
    end

    // registered read port, one cycle behind the address
    always_ff @(posedge clk) begin
        if (ram_rd_en) begin
            ram_rd_byte <= mem[ram_rd_addr];
        end
    end

    // unread flag marks a frame that is waiting for or under transmission
    always_ff @(posedge clk) begin
        if (reset) begin
            ram_unread <= 1'b0;
        end else if (ram_rd_done) begin
            ram_unread <= 1'b0;             // frame sent or aborted
        end else if (tx_start) begin
            ram_unread <= 1'b1;
        end
    end

endmodule

// ==== tx/cd_tx_bytes.sv ====
module cd_tx_bytes
    import cd_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    input  logic              user_crc,
    input  logic              abort,

    output logic [7:0]        data,
    output logic              has_data,
    input  logic              ack_data,
    output logic              is_crc_byte,
    output logic              is_last_byte,
    input  logic [15:0]       crc_data,

    input  logic              ram_unread,
    input  logic [7:0]        ram_rd_byte,
    output logic [addr_w-1:0] ram_rd_addr,
    output logic              ram_rd_en,
    output logic              ram_rd_done
);

    // one extra bit so the crc indices past the buffer end still compare
    localparam int cnt_w = $clog2(frame_max) + 1;

    logic [cnt_w-1:0] byte_cnt;
    logic [7:0]       data_len;         // copy of the length byte
    logic             rd_primed;        // first registered read has come back
    logic             frame_active;
    logic [cnt_w-1:0] crc_lo_idx;
    logic [cnt_w-1:0] crc_hi_idx;

    assign frame_active = ram_unread && !ram_rd_done;
    assign ram_rd_en    = frame_active;
    assign ram_rd_addr  = byte_cnt[addr_w-1:0];
    assign has_data     = frame_active && rd_primed;

    assign crc_lo_idx   = cnt_w'(data_len) + cnt_w'(hdr_len);
    assign crc_hi_idx   = crc_lo_idx + 1'b1;
    assign is_crc_byte  = (byte_cnt == crc_lo_idx);
    assign is_last_byte = (byte_cnt == crc_hi_idx);

    // the crc is settled long before its byte is loaded, so a plain mux will do
    always_comb begin
        data = ram_rd_byte;
        if (!user_crc) begin
            if (is_crc_byte) begin
                data = crc_data[7:0];       // low byte goes first
            end else if (is_last_byte) begin
                data = crc_data[15:8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !frame_active) begin
            byte_cnt  <= '0;
            data_len  <= '0;
            rd_primed <= 1'b0;
        end else begin
            rd_primed <= 1'b1;
            if (ack_data) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == cnt_w'(hdr_len - 1)) begin
                    data_len <= ram_rd_byte;
                end
            end
        end
    end

    // frame ends on the last ack or on abort, one cycle wide
    always_ff @(posedge clk) begin
        if (reset) begin
            ram_rd_done <= 1'b0;
        end else begin
            ram_rd_done <= frame_active && (abort || (is_last_byte && ack_data));
        end
    end

endmodule

// ==== tx/cd_crc16.sv ====
module cd_crc16
    import cd_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        frame_active,
    input  logic        ack_data,
    input  logic [7:0]  data,
    input  logic        is_crc_byte,
    input  logic        is_last_byte,
    output logic [15:0] crc_data
);

    // fold one byte, lsb first, into the reflected crc
    function automatic logic [15:0] crc_byte(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        c = crc ^ {8'h00, b};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ crc_poly) : (c >> 1);
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (reset || !frame_active) begin
            crc_data <= crc_init;
        end else if (ack_data && !is_crc_byte && !is_last_byte) begin
            crc_data <= crc_byte(crc_data, data);   // header and payload only
        end
    end

endmodule

// ==== tx/cd_tx_bits.sv ====
module cd_tx_bits
    import cd_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic [7:0] data,
    input  logic       has_data,
    output logic       ack_data,

    output logic       tx
);

    logic        busy;
    logic [15:0] div_cnt;       // cycles into the current bit
    logic [3:0]  bit_cnt;       // 0 start, 1..8 data, 9 stop
    logic [8:0]  shreg;         // remaining data bits with the stop bit on top
    logic        bit_end;
    logic        stop_end;
    logic        ready;

    // ########################################################################
    // load handshake
    // ########################################################################

    assign bit_end  = (div_cnt == bit_div - 16'd1);
    assign stop_end = busy && bit_end && (bit_cnt == 4'd9);

    // the last cycle of a stop bit counts as idle, so bytes go out back to back
    assign ready    = !busy || stop_end;
    assign ack_data = ready && has_data;

    // ########################################################################
    // bit timing and framing
    // ########################################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            tx      <= 1'b1;                // line idles high
        end else if (ack_data) begin
            busy    <= 1'b1;
            div_cnt <= '0;
            bit_cnt <= '0;
            tx      <= 1'b0;                // start bit
        end else if (busy) begin
            if (bit_end) begin
                div_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    // stop bit done and nothing waiting, line stays high
                    busy <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                    tx      <= shreg[0];
                end
            end else begin
                div_cnt <= div_cnt + 16'd1;
            end
        end
    end

    // data shifts out lsb first, ones fill in behind for the stop bit
    always_ff @(posedge clk) begin
        if (ack_data) begin
            shreg <= {1'b1, data};
        end else if (busy && bit_end) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

endmodule

// ==== source/cd_tx_top.sv ====
module cd_tx_top
    import cd_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    input  logic              wr_en,
    input  logic [addr_w-1:0] wr_addr,
    input  logic [7:0]        wr_byte,

    input  logic              tx_start,
    input  logic              user_crc,
    input  logic              abort,

    output logic              tx,
    output logic              tx_busy,
    output logic              tx_done
);

    // buffer <-> fetcher
    logic [addr_w-1:0] ram_rd_addr;
    logic              ram_rd_en;
    logic              ram_rd_done;
    logic [7:0]        ram_rd_byte;
    logic              ram_unread;

    // fetcher <-> serializer
    logic [7:0]        data;
    logic              has_data;
    logic              ack_data;
    logic              is_crc_byte;
    logic              is_last_byte;

    logic [15:0]       crc_data;
    logic              frame_active;

    assign frame_active = ram_unread && !ram_rd_done;   // crc restarts outside a frame
    assign tx_busy      = ram_unread;
    assign tx_done      = ram_rd_done;

    cd_tx_ram u_ram (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_byte      (wr_byte),
        .tx_start     (tx_start),
        .ram_rd_en    (ram_rd_en),
        .ram_rd_addr  (ram_rd_addr),
        .ram_rd_done  (ram_rd_done),
        .ram_rd_byte  (ram_rd_byte),
        .ram_unread   (ram_unread)
    );

    cd_tx_bytes u_bytes (
        .clk          (clk),
        .reset        (reset),
        .user_crc     (user_crc),
        .abort        (abort),
        .data         (data),
        .has_data     (has_data),
        .ack_data     (ack_data),
        .is_crc_byte  (is_crc_byte),
        .is_last_byte (is_last_byte),
        .crc_data     (crc_data),
        .ram_unread   (ram_unread),
        .ram_rd_byte  (ram_rd_byte),
        .ram_rd_addr  (ram_rd_addr),
        .ram_rd_en    (ram_rd_en),
        .ram_rd_done  (ram_rd_done)
    );

    cd_crc16 u_crc (
        .clk          (clk),
        .reset        (reset),
        .frame_active (frame_active),
        .ack_data     (ack_data),
        .data         (data),
        .is_crc_byte  (is_crc_byte),
        .is_last_byte (is_last_byte),
        .crc_data     (crc_data)
    );

    cd_tx_bits u_bits (
        .clk          (clk),
        .reset        (reset),
        .data         (data),
        .has_data     (has_data),
        .ack_data     (ack_data),
        .tx           (tx)
    );

endmodule

// ==== tb/cd_tx_props.sv ====
module cd_tx_props (
    input logic clk,
    input logic reset,
    input logic has_data,
    input logic ack_data,
    input logic ram_rd_done,
    input logic ram_unread,
    input logic is_crc_byte,
    input logic is_last_byte
);
    timeunit 1ns;
    timeprecision 1ps;

    logic seen_crc;         // low crc byte was offered in this frame
    int   fail_cnt = 0;     // assertion failures so far

    always_ff @(posedge clk) begin
        if (reset || !ram_unread) begin
            seen_crc <= 1'b0;
        end else if (has_data && is_crc_byte) begin
            seen_crc <= 1'b1;
        end
    end

    // ack is a single-cycle pulse and only answers an offered byte
    ack_needs_data: assert property (@(posedge clk) disable iff (reset)
        ack_data |=> ($past(has_data) && !ack_data))
        else begin
            fail_cnt++;
            $error("ack_data without has_data or longer than one cycle");
        end

    // the buffer drops its unread flag right after the done pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        ram_rd_done |=> (!ram_rd_done && !ram_unread))
        else begin
            fail_cnt++;
            $error("ram_rd_done held longer than one cycle or unread flag kept");
        end

    last_after_crc: assert property (@(posedge clk) disable iff (reset)
        (has_data && is_last_byte) |-> seen_crc)
        else begin
            fail_cnt++;
            $error("is_last_byte offered before any is_crc_byte");
        end

endmodule

bind cd_tx_bytes cd_tx_props u_props (.*);

// ==== tb/cd_tx_tb.sv ====
module cd_tx_tb;
    import cd_pkg::*;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_rec = 32;

    logic       clk;
    logic       reset;
    logic       wr_en;
    logic [7:0] wr_addr;
    logic [7:0] wr_byte;
    logic       tx_start;
    logic       user_crc;
    logic       abort;
    logic       tx;
    logic       tx_busy;
    logic       tx_done;

    int         errors;
    int         checks;
    int         started;        // start bits seen in the current frame
    int         done_cnt;
    logic [7:0] rx_q[$];
    logic       limit_ready;
    longint     limit_ns;

    // records from the data file
    int         n_rec;
    int         r_ucrc[max_rec];
    int         r_abort[max_rec];
    int         r_len[max_rec];
    int         r_cnt[max_rec];
    logic [7:0] r_src[max_rec];
    logic [7:0] r_dst[max_rec];
    logic [7:0] r_fill[max_rec];
    logic [7:0] r_clo[max_rec];
    logic [7:0] r_chi[max_rec];

    cd_tx_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_byte  (wr_byte),
        .tx_start (tx_start),
        .user_crc (user_crc),
        .abort    (abort),
        .tx       (tx),
        .tx_busy  (tx_busy),
        .tx_done  (tx_done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    function automatic logic [15:0] model_crc(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ b[i]) c = (c >> 1) ^ crc_poly;
            else c = c >> 1;
        end
        return c;
    endfunction

    // ########################################################################
    // line decoder and done counter
    // ########################################################################

    initial begin
        logic [7:0] b;
        forever begin
            @(negedge tx);
            started++;
            repeat (4) @(negedge clk);      // middle of the start bit
            check(tx, 1'b0, "start bit");
            for (int i = 0; i < 8; i++) begin
                repeat (bit_div) @(negedge clk);
                b[i] = tx;                  // lsb first
            end
            repeat (bit_div) @(negedge clk);
            check(tx, 1'b1, "stop bit");
            rx_q.push_back(b);
        end
    end

    always @(posedge clk) begin
        if (tx_done) done_cnt++;
    end

    initial begin
        wait (limit_ready);
        #(limit_ns);
        $display("timeout: the run did not finish within %0d ns", limit_ns);
        $display("Test failures found");
        $finish;
    end

    // ########################################################################
    // stimulus
    // ########################################################################

    task automatic read_records();
        int    fd;
        int    n;
        string line;
        fd = $fopen("tb/cd_tx_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            errors++;
            return;
        end
        while (!$feof(fd) && n_rec < max_rec) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%d %d %h %h %d %h %h %h %d", r_ucrc[n_rec], r_abort[n_rec],
                        r_src[n_rec], r_dst[n_rec], r_len[n_rec], r_fill[n_rec],
                        r_clo[n_rec], r_chi[n_rec], r_cnt[n_rec]);
            if (n == 9) n_rec++;
        end
        $fclose(fd);
    endtask

    task automatic write_byte(input logic [7:0] a, input logic [7:0] d);
        @(negedge clk);
        wr_en   = 1'b1;
        wr_addr = a;
        wr_byte = d;
        @(negedge clk);
        wr_en   = 1'b0;
    endtask

    task automatic run_frame(input int r);
        logic [7:0]  frame[$];
        logic [7:0]  exp[$];
        logic [15:0] crc;
        frame.push_back(r_src[r]);
        frame.push_back(r_dst[r]);
        frame.push_back(8'(r_len[r]));
        for (int i = 0; i < r_len[r]; i++) frame.push_back(8'(r_fill[r] + 13 * i));
        frame.push_back(r_clo[r]);
        frame.push_back(r_chi[r]);
        exp = frame;
        if (r_ucrc[r] == 0) begin
            crc = crc_init;
            for (int i = 0; i < hdr_len + r_len[r]; i++) crc = model_crc(crc, frame[i]);
            exp[hdr_len + r_len[r]]     = crc[7:0];
            exp[hdr_len + r_len[r] + 1] = crc[15:8];
        end
        foreach (frame[i]) begin
            if (i < frame_max) begin
                write_byte(8'(i), frame[i]);    // bytes past the buffer end would wrap
            end
        end

        rx_q.delete();
        started  = 0;
        done_cnt = 0;
        @(negedge clk);
        user_crc = r_ucrc[r][0];
        tx_start = 1'b1;
        @(negedge clk);
        tx_start = 1'b0;
        write_byte(8'd1, ~r_dst[r]);        // locked out while busy
        write_byte(8'(hdr_len), 8'h5a);

        if (r_abort[r] >= 0) begin
            wait (started == r_abort[r] + 1);
            repeat (3) @(negedge clk);
            abort = 1'b1;
            @(negedge clk);
            abort = 1'b0;
        end
        wait (done_cnt != 0);
        repeat (10 * bit_div + 4) @(negedge clk);   // let the last character drain

        check(done_cnt, 1, "tx_done pulses");
        check(tx_busy, 1'b0, "tx_busy after frame");
        check(tx, 1'b1, "line idle after frame");
        if (r_abort[r] >= 0) begin
            check(rx_q.size() <= r_abort[r] + 1, 1'b1, "bytes on line after abort");
        end else begin
            check(rx_q.size(), r_cnt[r], "bytes on line");
        end
        for (int i = 0; i < rx_q.size() && i < exp.size(); i++) begin
            check(rx_q[i], exp[i], $sformatf("record %0d byte %0d", r, i));
        end
    endtask

    initial begin
        longint      total;
        logic [15:0] c;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_byte     = '0;
        tx_start    = 1'b0;
        user_crc    = 1'b0;
        abort       = 1'b0;
        reset       = 1'b1;
        errors      = 0;
        checks      = 0;
        started     = 0;
        done_cnt    = 0;
        n_rec       = 0;
        limit_ready = 1'b0;
        void'($urandom(92217));

        // model sanity against the well known modbus vector "123456789"
        c = crc_init;
        for (int i = 0; i < 9; i++) c = model_crc(c, 8'h31 + 8'(i));
        check(c, 16'h4b37, "crc model check value");

        read_records();
        check(n_rec > 0, 1'b1, "records read");
        total = 0;
        for (int r = 0; r < n_rec; r++) total += r_len[r] + 5;
        limit_ns    = total * 10 * bit_div * 40 * 2 + n_rec * 20000 + 50000;
        limit_ready = 1'b1;

        repeat (3) @(negedge clk);
        reset = 1'b0;
        check(tx, 1'b1, "tx after reset");
        check(tx_busy, 1'b0, "tx_busy after reset");

        for (int r = 0; r < n_rec; r++) begin
            repeat (1 + $urandom % 20) @(negedge clk);
            run_frame(r);
        end

        check(u_dut.u_bytes.u_props.fail_cnt, 0, "bound assertion failures");

        $display("errors: %0d  checks: %0d  frames: %0d", errors, checks, n_rec);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
common/cd_pkg.sv
source/cd_tx_ram.sv
tx/cd_tx_bytes.sv
tx/cd_crc16.sv
tx/cd_tx_bits.sv
source/cd_tx_top.sv
tb/cd_tx_props.sv
tb/cd_tx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the transmit path testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f compile.f --top-module cd_tx_tb -o cd_tx_sim

out=$(./obj_dir/cd_tx_sim)
echo "$out"

# pass only when the testbench reports it
echo "$out" | grep -q "All tests passed!"

// ==== tb/cd_tx_testdata.txt ====
# user_crc abort_idx(-1 none) src dst len(dec) fill crc_lo crc_hi line_bytes(dec)
# payload byte i is fill + 13*i, crc columns are the buffer bytes at len+3 and len+4
0 -1 11 22 4 a0 00 00 9
0 -1 01 02 0 00 00 00 5
1 -1 05 06 3 30 34 12 8
0 -1 7e 81 253 5a 00 00 258
0 4 33 44 10 c3 00 00 5
0 -1 33 44 10 c3 00 00 15
1 -1 aa bb 0 00 ff ee 5
1 2 01 02 6 11 aa bb 3
0 -1 f0 0f 1 77 00 00 6
